// File: run_sim.sh
#!/usr/bin/env bash
# builds the tape subsystem testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f \
	--top-module tb_tape_subsystem \
	-o sim_tape
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_tape > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "=== PASS ===" sim.log; then
	exit 0
else
	exit 1
fi

// File: source/cassette_read_port.sv
// cassette input of the PIA, registers each deck's audio, flags falling edges and drives the lamp
`default_nettype none

module cassette_read_port (
	input  wire                                            clk,
	input  wire                                            rst,
	input  deck_pkg::deck_out_t [deck_pkg::NUM_DECKS-1:0]  outs,
	output logic [deck_pkg::NUM_DECKS-1:0]                 cass_read,
	output logic [deck_pkg::NUM_DECKS-1:0]                 cass_flag,
	output logic                                           tape_led
);

	// active bits gathered from the players for the lamp
	logic [deck_pkg::NUM_DECKS-1:0] active_bits;

	always_comb begin
		for (int d = 0; d < deck_pkg::NUM_DECKS; d++) begin
			active_bits[d] = outs[d].active;
		end
	end

	// cass_read is the audio one clk late
	// the flag goes up in the same clk in which cass_read is first seen low
	// so it marks a falling edge the way the PIA CA1 input latches it
	always_ff @(posedge clk) begin
		if (rst) begin
			cass_read <= '0;
			cass_flag <= '0;
			tape_led  <= 1'b0;
		end else begin
			for (int d = 0; d < deck_pkg::NUM_DECKS; d++) begin
				cass_read[d] <= outs[d].audio;
				cass_flag[d] <= cass_read[d] && !outs[d].audio;
			end
			// one lamp for all decks, lit while any of them is parsing
			tape_led <= |active_bits;
		end
	end

endmodule

`default_nettype wire

// File: source/ce_gen.sv
// divides clk down to the one-clk 1 MHz tick that paces the store reads and the tape players
`default_nettype none

module ce_gen (
	input  wire  clk,
	input  wire  rst,
	output logic ce_1m
);

	// counter wide enough to hold CE_DIV - 1
	typedef logic [$clog2(deck_pkg::CE_DIV)-1:0] div_t;

	div_t div_cnt;

	// the counter runs 0 .. CE_DIV-1 and the tick is registered on the wrap
	// so the first tick shows up CE_DIV clocks after rst is released
	always_ff @(posedge clk) begin
		if (rst) begin
			div_cnt <= '0;
			ce_1m   <= 1'b0;
		end else if (div_cnt == div_t'(deck_pkg::CE_DIV - 1)) begin
			div_cnt <= '0;
			ce_1m   <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			ce_1m   <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/deck_pkg.sv
// deck count, tick timing, store geometry and the structs passed between the tape modules
`default_nettype none

package deck_pkg;

	// number of identical tape players built by the top level
	localparam int NUM_DECKS = 2;

	// clk cycles per 1 MHz tick
	// the store needs NUM_DECKS + 1 clocks to answer, so this must be at least NUM_DECKS + 2
	localparam int CE_DIV = 8;

	// each deck owns a region of 2**REGION_W bytes and store addresses wrap inside it
	localparam int REGION_W = 12;

	// deck index, one bit for two decks
	typedef logic [$clog2(NUM_DECKS)-1:0] deck_sel_t;

	// byte read request from a player
	// rd is raised on a tick and held until the next tick, addr is a TAP byte offset
	typedef struct packed {
		logic                            rd;
		logic [tape_pkg::TAP_ADDR_W-1:0] addr;
	} tape_req_t;

	// what a player hands to the cassette read port
	typedef struct packed {
		logic audio;
		logic active;
	} deck_out_t;

	// one byte of a tape image download, wr is a one-clk strobe
	typedef struct packed {
		logic                wr;
		deck_sel_t           deck;
		logic [REGION_W-1:0] addr;
		logic [7:0]          data;
	} dl_beat_t;

endpackage

`default_nettype wire

// File: source/tape_image_store.sv
// on-chip tape image memory, loaded by the download port and read by the players in round-robin slots
`default_nettype none

module tape_image_store (
	input  wire                                                clk,
	input  wire                                                rst,
	input  wire                                                dl_active,
	input  deck_pkg::dl_beat_t                                 dl,
	input  deck_pkg::tape_req_t [deck_pkg::NUM_DECKS-1:0]      req,
	output logic [deck_pkg::NUM_DECKS-1:0]                     loading,
	output logic [deck_pkg::NUM_DECKS-1:0][7:0]                rd_data
);

	// one byte array split into NUM_DECKS regions
	// the deck index forms the top address bits, the region offset the low bits
	localparam int MEM_DEPTH = deck_pkg::NUM_DECKS << deck_pkg::REGION_W;

	logic [7:0] mem [MEM_DEPTH];

	// deck whose read request is looked at in this clk
	deck_pkg::deck_sel_t slot;

	// request of the deck that owns the current slot
	deck_pkg::tape_req_t slot_req;

	// region offset of that request, the upper address bits are dropped so reads wrap
	logic [deck_pkg::REGION_W-1:0] slot_ofs;

	// a deck is loading while a download is running and the beats are aimed at it
	// the player uses the falling edge of this level to start parsing
	always_comb begin
		for (int d = 0; d < deck_pkg::NUM_DECKS; d++) begin
			loading[d] = dl_active && (dl.deck == deck_pkg::deck_sel_t'(d));
		end
	end

	// download writes land one clock after the strobe
	always_ff @(posedge clk) begin
		if (dl.wr) begin
			mem[{dl.deck, dl.addr}] <= dl.data;
		end
	end

	// the slot counter steps through the decks one per clk
	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= '0;
		end else if (slot == deck_pkg::deck_sel_t'(deck_pkg::NUM_DECKS - 1)) begin
			slot <= '0;
		end else begin
			slot <= slot + 1'b1;
		end
	end

	assign slot_req = req[slot];
	assign slot_ofs = slot_req.addr[deck_pkg::REGION_W-1:0];

	// a single memory read port is shared by all decks
	// a deck whose rd is high gets its byte latched in its own slot
	// which takes at most NUM_DECKS + 1 clocks, well inside one tick period
	always_ff @(posedge clk) begin
		if (slot_req.rd) begin
			rd_data[slot] <= mem[{slot, slot_ofs}];
		end
	end

endmodule

`default_nettype wire

// File: source/tape_pkg.sv
// TAP image layout constants, shared by the image store, the tape players and the testbench
`default_nettype none

package tape_pkg;

	// the player starts reading at the version byte, the signature before it is skipped
	localparam int TAP_HEADER_START = 12;

	// first of the three little-endian bytes that give the number of data bytes
	localparam int TAP_SIZE_OFS = 16;

	// first pulse byte, right after the header
	localparam int TAP_DATA_OFS = 20;

	// width of a player byte address, wide enough for any image the core supports
	localparam int TAP_ADDR_W = 25;

	// a full pulse lasts value * 8 ticks of the 1 MHz enable
	localparam int PULSE_SHIFT = 3;

	// the high phase of a pulse lasts value * 4 ticks
	localparam int HALF_SHIFT = 2;

	// a zero pulse byte escapes to this many length bytes, least significant first
	localparam int LONG_LEN_BYTES = 3;

endpackage

`default_nettype wire

// File: source/tape_player.sv
// parses one TAP image from the store and plays it back as a square pulse train, with pause
`default_nettype none

module tape_player (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  ce_1m,
	input  wire                  loading,
	input  wire                  pause_btn,
	input  wire  [7:0]           rd_data,
	output deck_pkg::tape_req_t  req,
	output deck_pkg::deck_out_t  out
);

	typedef logic [tape_pkg::TAP_ADDR_W-1:0] addr_t;

	// length field after a zero escape
	typedef logic [8*tape_pkg::LONG_LEN_BYTES-1:0] long_t;

	// pulse countdown wide enough for a long length times eight
	typedef logic [8*tape_pkg::LONG_LEN_BYTES+tape_pkg::PULSE_SHIFT-1:0] pulse_t;

	// counts the long length bytes still to gather
	typedef logic [$clog2(tape_pkg::LONG_LEN_BYTES+1)-1:0] reload_t;

	// counts the bytes left to consume, first in the header and then in the data
	long_t   byte_cnt;
	long_t   size;
	long_t   long_len;
	long_t   long_len_lo;
	pulse_t  bit_cnt;
	pulse_t  bit_half;
	reload_t reload;
	addr_t   addr;
	logic    rd;
	logic    audio;
	logic    load_d;
	logic    byte_ready;
	logic [7:0] din;
	logic    pause_d;
	logic    paused;

	// the long length is built little endian and the newest byte goes on top
	assign long_len = {din, long_len_lo[$bits(long_t)-1:8]};

	// a rising edge of the button toggles playback
	// a new download always starts unpaused
	always_ff @(posedge clk) begin
		if (rst) begin
			pause_d <= 1'b0;
			paused  <= 1'b0;
		end else begin
			pause_d <= pause_btn;
			if (loading) begin
				paused <= 1'b0;
			end else if (pause_btn && !pause_d) begin
				paused <= !paused;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst || loading) begin
			byte_cnt   <= '0;
			size       <= '0;
			bit_cnt    <= '0;
			reload     <= '0;
			rd         <= 1'b0;
			audio      <= 1'b0;
			byte_ready <= 1'b0;
			load_d     <= loading;
		end else if (ce_1m) begin
			load_d <= loading;
			rd     <= 1'b0;

			// the store answered within this tick period so the byte is taken now
			if (rd) begin
				byte_ready <= 1'b1;
				din        <= rd_data;
			end

			// when the download has just finished the version byte is fetched first
			if (load_d) begin
				byte_cnt <= long_t'(tape_pkg::TAP_DATA_OFS - tape_pkg::TAP_HEADER_START);
				rd       <= 1'b1;
				addr     <= addr_t'(tape_pkg::TAP_HEADER_START);
			end

			if (byte_cnt != '0 && byte_ready) begin
				if (addr < addr_t'(tape_pkg::TAP_DATA_OFS)) begin
					// the header is walked one byte every two ticks
					byte_cnt   <= byte_cnt - 1'b1;
					addr       <= addr + 1'b1;
					byte_ready <= 1'b0;
					rd         <= 1'b1;
					if (addr >= addr_t'(tape_pkg::TAP_SIZE_OFS) &&
						addr < addr_t'(tape_pkg::TAP_DATA_OFS - 1)) begin
						size <= {din, size[$bits(size)-1:8]};
					end
					// at the last header byte the count becomes the data size
					// so an empty image ends right here
					if (addr == addr_t'(tape_pkg::TAP_DATA_OFS - 1)) begin
						byte_cnt <= size;
					end
				end else if (bit_cnt <= pulse_t'(1) && !paused) begin
					// once the previous pulse is done the next data byte is consumed
					byte_cnt   <= byte_cnt - 1'b1;
					addr       <= addr + 1'b1;
					byte_ready <= 1'b0;
					rd         <= 1'b1;
					if (reload != '0) begin
						long_len_lo <= long_len;
						reload      <= reload - 1'b1;
						// the last length byte starts one long pulse
						if (reload == reload_t'(1)) begin
							bit_cnt  <= pulse_t'(long_len) << tape_pkg::PULSE_SHIFT;
							bit_half <= pulse_t'(long_len) << tape_pkg::HALF_SHIFT;
							audio    <= 1'b1;
						end
					end else if (din == 8'd0) begin
						// zero byte escapes to a 24-bit length
						reload <= reload_t'(tape_pkg::LONG_LEN_BYTES);
					end else begin
						bit_cnt  <= pulse_t'(din) << tape_pkg::PULSE_SHIFT;
						bit_half <= pulse_t'(din) << tape_pkg::HALF_SHIFT;
						audio    <= 1'b1;
					end
				end
			end

			// the countdown keeps going after the last byte so the final pulse completes
			// and audio drops once half of the pulse has passed
			if (!paused && bit_cnt > pulse_t'(1)) begin
				bit_cnt <= bit_cnt - 1'b1;
				if (bit_cnt < bit_half) begin
					audio <= 1'b0;
				end
			end
		end
	end

	assign req.rd     = rd;
	assign req.addr   = addr;
	assign out.audio  = audio;
	assign out.active = (byte_cnt != '0);

endmodule

`default_nettype wire

// File: source/tape_subsystem.sv
// top of the cassette subsystem, ties the tick, the image store, the players and the read port
`default_nettype none

module tape_subsystem (
	input  wire                              clk,
	input  wire                              rst,
	input  wire                              dl_active,
	input  deck_pkg::dl_beat_t               dl,
	input  wire  [deck_pkg::NUM_DECKS-1:0]   pause_btn,
	output logic [deck_pkg::NUM_DECKS-1:0]   cass_read,
	output logic [deck_pkg::NUM_DECKS-1:0]   cass_flag,
	output logic                             tape_led
);

	logic                                        ce_1m;
	logic [deck_pkg::NUM_DECKS-1:0]              loading;
	logic [deck_pkg::NUM_DECKS-1:0][7:0]         rd_data;
	deck_pkg::tape_req_t [deck_pkg::NUM_DECKS-1:0] req;
	deck_pkg::deck_out_t [deck_pkg::NUM_DECKS-1:0] outs;

	ce_gen i_ce_gen (
		.clk   (clk),
		.rst   (rst),
		.ce_1m (ce_1m)
	);

	tape_image_store i_store (
		.clk       (clk),
		.rst       (rst),
		.dl_active (dl_active),
		.dl        (dl),
		.req       (req),
		.loading   (loading),
		.rd_data   (rd_data)
	);

	// one player per deck, each reads only its own store region
	for (genvar g = 0; g < deck_pkg::NUM_DECKS; g++) begin : g_deck
		tape_player i_player (
			.clk       (clk),
			.rst       (rst),
			.ce_1m     (ce_1m),
			.loading   (loading[g]),
			.pause_btn (pause_btn[g]),
			.rd_data   (rd_data[g]),
			.req       (req[g]),
			.out       (outs[g])
		);
	end

	cassette_read_port i_read_port (
		.clk       (clk),
		.rst       (rst),
		.outs      (outs),
		.cass_read (cass_read),
		.cass_flag (cass_flag),
		.tape_led  (tape_led)
	);

endmodule

`default_nettype wire

// File: testbench/tape_assertions.sv
// concurrent checks on the tick spacing, read timing, flag shape and reset state, bound to the top
`default_nettype none

module tape_assertions (
	input wire                                            clk,
	input wire                                            rst,
	input wire                                            ce_1m,
	input deck_pkg::tape_req_t [deck_pkg::NUM_DECKS-1:0]  req,
	input deck_pkg::deck_sel_t                            slot,
	input wire  [deck_pkg::NUM_DECKS-1:0]                 cass_read,
	input wire  [deck_pkg::NUM_DECKS-1:0]                 cass_flag,
	input wire                                            tape_led
);

	// clocks since the last tick, and whether a tick has been seen at all
	int   since_ce;
	logic ce_seen;

	always_ff @(posedge clk) begin
		if (rst) begin
			since_ce <= 0;
			ce_seen  <= 1'b0;
		end else if (ce_1m) begin
			since_ce <= 0;
			ce_seen  <= 1'b1;
		end else begin
			since_ce <= since_ce + 1;
		end
	end

	// ticks must be exactly CE_DIV clocks apart
	ce_spacing: assert property (@(posedge clk) disable iff (rst)
		(ce_1m && ce_seen) |-> (since_ce == deck_pkg::CE_DIV - 1))
		else $error("ce_1m tick spacing is not CE_DIV clocks");

	// nothing is lit in the clk after reset
	reset_quiet: assert property (@(posedge clk)
		rst |=> (cass_read == '0 && cass_flag == '0 && !tape_led))
		else $error("outputs are not quiet after reset");

	for (genvar d = 0; d < deck_pkg::NUM_DECKS; d++) begin : g_deck_chk
		// set once the store slot has visited this deck while its read was pending
		logic served;

		always_ff @(posedge clk) begin
			if (rst || ce_1m) begin
				served <= 1'b0;
			end else if (req[d].rd && slot == deck_pkg::deck_sel_t'(d)) begin
				served <= 1'b1;
			end
		end

		// a pending read must have had its store slot before the player samples it
		rd_answered: assert property (@(posedge clk) disable iff (rst)
			(ce_1m && req[d].rd) |-> served)
			else $error("read request not served before the next tick");

		// a flag marks the clk in which the read line is first low
		flag_on_fall: assert property (@(posedge clk) disable iff (rst)
			cass_flag[d] |-> ($past(cass_read[d]) && !cass_read[d]))
			else $error("cass_flag without a falling read line");
	end

endmodule

bind tape_subsystem tape_assertions i_tape_assertions (
	.clk       (clk),
	.rst       (rst),
	.ce_1m     (ce_1m),
	.req       (req),
	.slot      (i_store.slot),
	.cass_read (cass_read),
	.cass_flag (cass_flag),
	.tape_led  (tape_led)
);

`default_nettype wire

// File: testbench/tb_tape_subsystem.sv
// directed testbench of the tape subsystem, builds TAP images, plays them and times the pulses
`default_nettype none

module tb_tape_subsystem;

	localparam int ND = deck_pkg::NUM_DECKS;
	localparam int MAX_B = 20;
	localparam int HDR = 40;

	// ticks of every test including the 100 frozen ticks of the pause test
	localparam int TEST_TICKS = (8 * 5 * MAX_B + HDR) + (8 * (40 + 4) + HDR)
		+ (8 * 20 + 100 + HDR) + (8 * 4 * MAX_B + HDR) + HDR + 5 * 200;
	localparam int LIMIT = TEST_TICKS * deck_pkg::CE_DIV * 2;

	logic clk = 1'b0;
	logic rst;
	logic dl_active;
	deck_pkg::dl_beat_t dl;
	logic [ND-1:0] pause_btn;
	logic [ND-1:0] cass_read;
	logic [ND-1:0] cass_flag;
	logic tape_led;

	int err_cnt = 0;
	int cycles = 0;
	int seed = 71672;

	// pulse bytes of each deck and the expected length of each pulse in units of 8 ticks
	logic [7:0] img_mem [ND][64];
	int img_n [ND];
	int exp_len [ND][16];
	int exp_n [ND];

	tape_subsystem i_dut (
		.clk       (clk),
		.rst       (rst),
		.dl_active (dl_active),
		.dl        (dl),
		.pause_btn (pause_btn),
		.cass_read (cass_read),
		.cass_flag (cass_flag),
		.tape_led  (tape_led)
	);

	always #50 clk = !clk;

	// the run is stopped once the cycle count passes twice the length of all tests
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > LIMIT) begin
			$display("timeout, the tests did not finish within %0d cycles", LIMIT);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic check_near(input string sig, input int exp, input int act, input int tol);
		assert (act >= exp - tol && act <= exp + tol) else begin
			err_cnt++;
			$display("[FAIL] t=%0t %s expected %0d got %0d", $time, sig, exp, act);
		end
	endtask

	task automatic wait_ticks(input int n);
		int k;
		k = 0;
		while (k < n) begin
			@(negedge clk);
			if (i_dut.ce_1m) k++;
		end
	endtask

	task automatic clear_image(input int d);
		img_n[d] = 0;
		exp_n[d] = 0;
	endtask

	task automatic add_pulse(input int d, input int b);
		img_mem[d][img_n[d]] = 8'(b);
		img_n[d]++;
		exp_len[d][exp_n[d]] = b;
		exp_n[d]++;
	endtask

	// zero escape followed by a little-endian 24-bit length
	task automatic add_long(input int d, input int len);
		add_pulse(d, 0);
		exp_n[d]--;
		for (int i = 0; i < 3; i++) begin
			img_mem[d][img_n[d]] = 8'(len >> (8 * i));
			img_n[d]++;
		end
		exp_len[d][exp_n[d]] = len;
		exp_n[d]++;
	endtask

	task automatic write_byte(input int d, input int a, input logic [7:0] v);
		dl.wr   = 1'b1;
		dl.deck = deck_pkg::deck_sel_t'(d);
		dl.addr = a[deck_pkg::REGION_W-1:0];
		dl.data = v;
		@(negedge clk);
		dl.wr = 1'b0;
	endtask

	// header with signature, version 1 and the size field, then the pulse bytes
	task automatic load_image(input int d, input int size_field);
		string sig;
		logic [7:0] v;
		sig = "C64-TAPE-RAW";
		@(negedge clk);
		dl_active = 1'b1;
		dl.deck   = deck_pkg::deck_sel_t'(d);
		for (int a = 0; a < tape_pkg::TAP_DATA_OFS; a++) begin
			v = 8'd0;
			if (a < tape_pkg::TAP_HEADER_START) v = sig[a];
			if (a == tape_pkg::TAP_HEADER_START) v = 8'd1;
			if (a >= tape_pkg::TAP_SIZE_OFS && a < tape_pkg::TAP_SIZE_OFS + 3)
				v = 8'(size_field >> (8 * (a - tape_pkg::TAP_SIZE_OFS)));
			write_byte(d, a, v);
		end
		for (int i = 0; i < img_n[d]; i++) begin
			write_byte(d, tape_pkg::TAP_DATA_OFS + i, img_mem[d][i]);
		end
		dl_active = 1'b0;
	endtask

	// times each pulse of a deck against its expected length and counts the flags
	task automatic watch_deck(input int d);
		int hi;
		int per;
		int flags;
		while (!cass_read[d]) @(negedge clk);
		for (int i = 0; i < exp_n[d]; i++) begin
			hi = 0;
			per = 0;
			flags = 0;
			while (cass_read[d]) begin
				@(negedge clk);
				if (i_dut.ce_1m) begin
					hi++;
					per++;
				end
				if (cass_flag[d]) flags++;
			end
			check_near($sformatf("deck %0d pulse %0d high ticks", d, i), 4 * exp_len[d][i], hi, 2);
			check_near($sformatf("deck %0d pulse %0d cass_flag count", d, i), 1, flags, 0);
			// the last pulse has no following rise to close its period
			if (i < exp_n[d] - 1) begin
				while (!cass_read[d]) begin
					@(negedge clk);
					if (i_dut.ce_1m) per++;
				end
				check_near($sformatf("deck %0d pulse %0d period ticks", d, i),
					8 * exp_len[d][i], per, 2);
			end
		end
	endtask

	task automatic idle_quiet();
		for (int k = 0; k < 400; k++) begin
			@(negedge clk);
			assert (cass_read == '0 && cass_flag == '0 && !tape_led) else begin
				err_cnt++;
				$display("outputs became active with no tape image loaded at t=%0t", $time);
				break;
			end
		end
	endtask

	task automatic random_pulses();
		clear_image(0);
		for (int i = 0; i < 5; i++) add_pulse(0, 4 + ($unsigned($random(seed)) % 17));
		load_image(0, img_n[0]);
		fork
			watch_deck(0);
			begin
				while (!cass_read[0]) @(negedge clk);
				check_near("tape_led while playing", 1, tape_led, 0);
			end
		join
		check_near("tape_led after the last byte", 0, tape_led, 0);
		wait_ticks(200);
	endtask

	task automatic long_escape_pulse();
		clear_image(0);
		add_long(0, 40);
		// a short pulse after the long one closes its period
		add_pulse(0, 4);
		load_image(0, img_n[0]);
		watch_deck(0);
		wait_ticks(200);
	endtask

	task automatic press_pause(input int d);
		@(negedge clk);
		pause_btn[d] = 1'b1;
		@(negedge clk);
		pause_btn[d] = 1'b0;
	endtask

	task automatic pause_and_resume();
		int hi;
		clear_image(0);
		// without the pause this high phase would end inside the 100 frozen ticks
		add_pulse(0, 20);
		load_image(0, img_n[0]);
		while (!cass_read[0]) @(negedge clk);
		wait_ticks(20);
		press_pause(0);
		for (int k = 0; k < 100; k++) begin
			wait_ticks(1);
			assert (cass_read[0] && !cass_flag[0]) else begin
				err_cnt++;
				$display("deck 0 read line moved while paused at t=%0t", $time);
				break;
			end
		end
		press_pause(0);
		hi = 20;
		while (cass_read[0]) begin
			@(negedge clk);
			if (i_dut.ce_1m) hi++;
		end
		check_near("paused pulse high ticks", 4 * 20, hi, 2);
		check_near("cass_flag after resume", 1, cass_flag[0], 0);
		wait_ticks(200);
	endtask

	task automatic two_decks_at_once();
		clear_image(0);
		clear_image(1);
		for (int i = 0; i < 4; i++) add_pulse(0, 4 + ($unsigned($random(seed)) % 17));
		for (int i = 0; i < 3; i++) add_pulse(1, 4 + ($unsigned($random(seed)) % 17));
		load_image(0, img_n[0]);
		load_image(1, img_n[1]);
		fork
			watch_deck(0);
			watch_deck(1);
		join
		wait_ticks(200);
	endtask

	task automatic empty_image_silent();
		int flags;
		clear_image(1);
		load_image(1, 0);
		flags = 0;
		while (!tape_led) @(negedge clk);
		while (tape_led) begin
			@(negedge clk);
			if (cass_flag != '0) flags++;
		end
		for (int k = 0; k < 30 * deck_pkg::CE_DIV; k++) begin
			@(negedge clk);
			if (cass_flag != '0 || tape_led) flags++;
		end
		check_near("flags or lamp after an empty image", 0, flags, 0);
	endtask

	initial begin
		rst       = 1'b1;
		dl_active = 1'b0;
		dl        = '0;
		pause_btn = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		idle_quiet();
		random_pulses();
		long_escape_pulse();
		pause_and_resume();
		two_decks_at_once();
		empty_image_silent();
		$display("errors: %0d", err_cnt);
		if (err_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
source/tape_pkg.sv
source/deck_pkg.sv
source/ce_gen.sv
source/tape_image_store.sv
source/tape_player.sv
source/cassette_read_port.sv
source/tape_subsystem.sv
testbench/tape_assertions.sv
testbench/tb_tape_subsystem.sv
